// ==== verilog/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

	// ==========================================================================
	// widths
	// ==========================================================================

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int OP_W = 6;

	// 64 byte cache line
	localparam int LINE_BITS = 6;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// ==========================================================================
	// opcodes and access size
	// ==========================================================================

	typedef enum logic [OP_W-1:0] {
		// displacement form
		LDB    = 6'h01,
		LDBU   = 6'h02,
		LDH    = 6'h03,
		LDHU   = 6'h04,
		LDW    = 6'h05,
		STB    = 6'h09,
		STH    = 6'h0a,
		STW    = 6'h0b,
		// indexed form, size carried in the instruction
		LDX    = 6'h10,
		STX    = 6'h11,
		// atomic swap, read then write of one word
		AMOSWP = 6'h20
	} op_t;

	typedef enum logic [1:0] {
		SZ_BYTE = 2'd0,
		SZ_HALF = 2'd1,
		SZ_WORD = 2'd2
	} size_t;

	// bus master state encoding
	localparam logic [2:0] ST_IDLE   = 3'd0;
	localparam logic [2:0] ST_READ   = 3'd1;
	localparam logic [2:0] ST_GAP    = 3'd2;
	localparam logic [2:0] ST_WRITE  = 3'd3;
	localparam logic [2:0] ST_FINISH = 3'd4;

	// ==========================================================================
	// instruction word, two decodes of the same 32 bits
	// ==========================================================================

	// opcode sits in the top six bits in both views
	typedef struct packed {
		op_t                opcode;
		logic [9:0]         rsvd;
		logic signed [15:0] disp;
	} insn_disp_t;

	typedef struct packed {
		op_t               opcode;
		logic [11:0]       rsvd;
		size_t             size;
		logic [1:0]        sc;
		logic signed [9:0] disp;
	} insn_idx_t;

	typedef union packed {
		insn_disp_t disp;
		insn_idx_t  idx;
	} lsu_insn_u;

endpackage

`default_nettype wire

// ==== verilog/agen_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one generated access, held until the bus master reports it finished
interface agen_if;
	import lsu_pkg::*;

	// aligned byte address
	addr_t addr;
	op_t   op;
	size_t size;
	// store data, right justified
	data_t data;
	// sticky, stays up until done
	logic  valid;
	// single cycle pulse from the master
	logic  done;

	modport agen (
		output addr,
		output op,
		output size,
		output data,
		output valid,
		input  done
	);

	modport master (
		input  addr,
		input  op,
		input  size,
		input  data,
		input  valid,
		output done
	);

endinterface

`default_nettype wire

// ==== verilog/lsu_agen.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_agen (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    issue_valid,
	input  wire lsu_pkg::lsu_insn_u issue_insn,
	input  wire lsu_pkg::addr_t    issue_a,
	input  wire lsu_pkg::addr_t    issue_b,
	input  wire lsu_pkg::data_t    issue_data,
	// jump to the start of the following line
	input  wire                    next_line,
	output logic                   issue_ready,
	agen_if.agen                   acc
);
	import lsu_pkg::*;

	addr_t disp16_ext;
	addr_t disp10_ext;
	addr_t idx_scaled;
	addr_t addr_raw;
	addr_t addr_aln;
	size_t size_dec;
	logic  pending;
	logic  accept;

	// ==========================================================================
	// issue handshake
	// ==========================================================================

	// one access at a time, free only when both stages are empty
	assign issue_ready = !pending && !acc.valid;
	assign accept = issue_valid && issue_ready;

	// ==========================================================================
	// address calculation
	// ==========================================================================

	assign disp16_ext = {{(ADDR_W-16){issue_insn.disp.disp[15]}}, issue_insn.disp.disp};
	assign disp10_ext = {{(ADDR_W-10){issue_insn.idx.disp[9]}}, issue_insn.idx.disp};

	// index scaled by 1, 2, 4 or 8
	assign idx_scaled = issue_b << issue_insn.idx.sc;

	always_comb begin
		case (issue_insn.disp.opcode)
		LDB, LDBU, STB: begin
			addr_raw = issue_a + disp16_ext;
			size_dec = SZ_BYTE;
		end
		LDH, LDHU, STH: begin
			addr_raw = issue_a + disp16_ext;
			size_dec = SZ_HALF;
		end
		LDW, STW: begin
			addr_raw = issue_a + disp16_ext;
			size_dec = SZ_WORD;
		end
		LDX, STX: begin
			// size field only exists in the indexed view
			addr_raw = issue_a + idx_scaled + disp10_ext;
			size_dec = issue_insn.idx.size;
		end
		AMOSWP: begin
			addr_raw = issue_a + issue_b;
			size_dec = SZ_WORD;
		end
		default: begin
			addr_raw = '0;
			size_dec = SZ_WORD;
		end
		endcase
	end

	// drop the low bits below the access size
	always_comb begin
		case (size_dec)
		SZ_HALF: addr_aln = {addr_raw[ADDR_W-1:1], 1'b0};
		SZ_WORD: addr_aln = {addr_raw[ADDR_W-1:2], 2'b00};
		default: addr_aln = addr_raw;
		endcase
	end

	// capture on acceptance, payload holds while the access runs
	always_ff @(posedge clk) begin
		if (accept) begin
			if (next_line)
				acc.addr <= {addr_raw[ADDR_W-1:LINE_BITS] + 1'b1, {LINE_BITS{1'b0}}};
			else
				acc.addr <= addr_aln;
			acc.op <= issue_insn.disp.opcode;
			acc.size <= size_dec;
			acc.data <= issue_data;
		end
	end

	// ==========================================================================
	// two stage sticky valid
	// ==========================================================================

	// pending follows acceptance, valid follows pending one cycle later
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
			acc.valid <= 1'b0;
		end else begin
			if (accept)
				pending <= 1'b1;
			acc.valid <= pending;
			// completion from the master empties both stages
			if (acc.done) begin
				pending <= 1'b0;
				acc.valid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lsu_wb_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_wb_master (
	input  wire                 clk,
	input  wire                 rst,
	agen_if.master              acc,
	// wishbone classic
	output logic                wb_cyc,
	output logic                wb_stb,
	output logic                wb_we,
	output logic [3:0]          wb_sel,
	output lsu_pkg::addr_t      wb_adr,
	output lsu_pkg::data_t      wb_dat_o,
	input  wire lsu_pkg::data_t wb_dat_i,
	input  wire                 wb_ack,
	// result
	output logic                done,
	output lsu_pkg::data_t      load_data
);
	import lsu_pkg::*;

	logic [2:0] state;
	logic       is_store;
	logic       is_swap;
	logic       sign_ext;
	logic [4:0] lane_shift;
	data_t      lane_data;
	data_t      ext_data;

	// ==========================================================================
	// decode of the held access
	// ==========================================================================

	assign is_swap = (acc.op == AMOSWP);
	assign is_store = acc.op inside {STB, STH, STW, STX};
	// indexed loads come back zero extended
	assign sign_ext = acc.op inside {LDB, LDH};

	// ==========================================================================
	// bus signals
	// ==========================================================================

	// cyc and stb together for the whole read or write phase
	assign wb_cyc = (state == ST_READ) || (state == ST_WRITE);
	assign wb_stb = wb_cyc;
	assign wb_we = (state == ST_WRITE);
	// address is already size aligned and held by the agen
	assign wb_adr = acc.addr;

	// byte lanes, little endian
	always_comb begin
		case (acc.size)
		SZ_BYTE: wb_sel = 4'b0001 << acc.addr[1:0];
		SZ_HALF: wb_sel = 4'b0011 << {acc.addr[1], 1'b0};
		default: wb_sel = 4'b1111;
		endcase
	end

	// store data copied into every lane, sel picks the live one
	always_comb begin
		case (acc.size)
		SZ_BYTE: wb_dat_o = {4{acc.data[7:0]}};
		SZ_HALF: wb_dat_o = {2{acc.data[15:0]}};
		default: wb_dat_o = acc.data;
		endcase
	end

	// ==========================================================================
	// load alignment and extension
	// ==========================================================================

	assign lane_shift = {acc.addr[1:0], 3'b000};
	assign lane_data = wb_dat_i >> lane_shift;

	always_comb begin
		case (acc.size)
		SZ_BYTE:
			if (sign_ext)
				ext_data = {{24{lane_data[7]}}, lane_data[7:0]};
			else
				ext_data = {24'd0, lane_data[7:0]};
		SZ_HALF:
			if (sign_ext)
				ext_data = {{16{lane_data[15]}}, lane_data[15:0]};
			else
				ext_data = {16'd0, lane_data[15:0]};
		default:
			ext_data = lane_data;
		endcase
	end

	// ==========================================================================
	// cycle sequencing
	// ==========================================================================

	// swap is read, one idle cycle, then write to the same address
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
			ST_IDLE:
				if (acc.valid)
					state <= is_store ? ST_WRITE : ST_READ;
			ST_READ:
				if (wb_ack)
					state <= is_swap ? ST_GAP : ST_FINISH;
			ST_GAP:
				state <= ST_WRITE;
			ST_WRITE:
				if (wb_ack)
					state <= ST_FINISH;
			// finish lasts one cycle, agen drops valid at the same edge
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// read ack gives the load result, for a swap the old word
	always_ff @(posedge clk) begin
		if (state == ST_READ && wb_ack)
			load_data <= ext_data;
		else if (state == ST_WRITE && wb_ack && !is_swap)
			load_data <= '0;
	end

	// one cycle after the last ack
	assign done = (state == ST_FINISH);
	assign acc.done = done;

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
	input  wire                     clk,
	input  wire                     rst,
	// ==========================================================================
	// issue
	// ==========================================================================
	input  wire                     issue_valid,
	input  wire lsu_pkg::lsu_insn_u issue_insn,
	input  wire lsu_pkg::addr_t     issue_a,
	input  wire lsu_pkg::addr_t     issue_b,
	input  wire lsu_pkg::data_t     issue_data,
	input  wire                     next_line,
	output logic                    issue_ready,
	// ==========================================================================
	// result
	// ==========================================================================
	output logic                    done,
	output lsu_pkg::data_t          load_data,
	// ==========================================================================
	// wishbone classic
	// ==========================================================================
	output logic                    wb_cyc,
	output logic                    wb_stb,
	output logic                    wb_we,
	output logic [3:0]              wb_sel,
	output lsu_pkg::addr_t          wb_adr,
	output lsu_pkg::data_t          wb_dat_o,
	input  wire lsu_pkg::data_t     wb_dat_i,
	input  wire                     wb_ack
);

	// generated access between agen and master
	agen_if u_acc ();

	// address generation and the sticky valid
	lsu_agen u_agen (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_insn  (issue_insn),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.issue_data  (issue_data),
		.next_line   (next_line),
		.issue_ready (issue_ready),
		.acc         (u_acc.agen)
	);

	// bus cycles, lane steering and completion
	lsu_wb_master u_master (
		.clk       (clk),
		.rst       (rst),
		.acc       (u_acc.master),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_sel    (wb_sel),
		.wb_adr    (wb_adr),
		.wb_dat_o  (wb_dat_o),
		.wb_dat_i  (wb_dat_i),
		.wb_ack    (wb_ack),
		.done      (done),
		.load_data (load_data)
	);

endmodule

`default_nettype wire

// ==== dv/wb_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

// wishbone classic slave, 256 words at address zero
module wb_mem_model (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 cyc,
	input  wire                 stb,
	input  wire                 we,
	input  wire [3:0]           sel,
	input  wire lsu_pkg::addr_t adr,
	input  wire lsu_pkg::data_t dat_w,
	output lsu_pkg::data_t      dat_r,
	output logic                ack
);
	import lsu_pkg::*;

	data_t       mem [0:255];
	logic [1:0]  wait_cnt;
	logic [31:0] draw;

	// every address bit feeds the word, so a wrong index shows up
	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = (32'(i) << 2) * 32'h9e37_79b1 ^ 32'h0bad_f00d;
	end

	// ==========================================================================
	// ack after 0 to 3 wait cycles, drawn from the run-wide generator
	// ==========================================================================

	always @(posedge clk) begin
		draw = $urandom;
		if (rst) begin
			ack <= 1'b0;
			wait_cnt <= draw[1:0];
		end else if (ack) begin
			// single ack, master drops cyc on this edge
			ack <= 1'b0;
			wait_cnt <= draw[1:0];
		end else if (cyc && stb) begin
			if (wait_cnt == 2'd0) begin
				ack <= 1'b1;
				dat_r <= mem[adr[9:2]];
				if (we) begin
					for (int k = 0; k < 4; k++)
						if (sel[k])
							mem[adr[9:2]][8*k +: 8] <= dat_w[8*k +: 8];
				end
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end else begin
			// idle, fresh delay for the next cycle
			wait_cnt <= draw[1:0];
		end
	end

endmodule

`default_nettype wire

// ==== dv/lsu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;
	import lsu_pkg::*;

	localparam int N_ACC = 400;
	localparam int RST_CYC = 16;
	// a swap with slow acks is the longest access
	localparam int LIMIT = RST_CYC + N_ACC * 12;

	logic      clk;
	logic      rst;
	logic      issue_valid;
	lsu_insn_u issue_insn;
	addr_t     issue_a;
	addr_t     issue_b;
	data_t     issue_data;
	logic      next_line;
	logic      issue_ready;
	logic      done;
	data_t     load_data;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	logic [3:0] wb_sel;
	addr_t     wb_adr;
	data_t     wb_dat_o;
	data_t     wb_dat_i;
	logic      wb_ack;

	// shadow of the slave memory
	data_t shadow [0:255];
	int    cycles = 0;
	int    n_issued = 0;

	lsu_top UUT (.*);

	wb_mem_model u_mem (
		.clk   (clk),
		.rst   (rst),
		.cyc   (wb_cyc),
		.stb   (wb_stb),
		.we    (wb_we),
		.sel   (wb_sel),
		.adr   (wb_adr),
		.dat_w (wb_dat_o),
		.dat_r (wb_dat_i),
		.ack   (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("run hung: %0d accesses issued after %0d cycles", n_issued, cycles);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	// ==========================================================================
	// helpers
	// ==========================================================================

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %08h expected %08h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "compare failed");
		end
	endtask

	function automatic logic [31:0] rand_below(input int unsigned n);
		return $urandom % n;
	endfunction

	// same contents the slave starts with
	function automatic data_t fill_word(input int i);
		return (32'(i) << 2) * 32'h9e37_79b1 ^ 32'h0bad_f00d;
	endfunction

	// ==========================================================================
	// one access: issue, watch the bus, compare against the model
	// ==========================================================================

	task automatic run_access(input lsu_insn_u insn, input addr_t a, input addr_t b,
			input data_t wdata, input logic line);
		op_t        op;
		size_t      sz;
		addr_t      raw;
		addr_t      adr;
		logic [3:0] sel;
		data_t      rep;
		data_t      old;
		data_t      lane;
		data_t      exp_ld;
		logic       is_store;
		logic       exp_we;
		int         n_exp;
		int         n_tr;
		logic       held;
		addr_t      p_adr;
		data_t      p_dat;
		logic [4:0] p_ctl;

		op = insn.disp.opcode;
		is_store = op inside {STB, STH, STW, STX};
		case (op)
		LDB, LDBU, STB: sz = SZ_BYTE;
		LDH, LDHU, STH: sz = SZ_HALF;
		LDX, STX: sz = insn.idx.size;
		default: sz = SZ_WORD;
		endcase
		// effective address per form
		if (op == LDX || op == STX)
			raw = a + (b << insn.idx.sc) + {{22{insn.idx.disp[9]}}, insn.idx.disp};
		else if (op == AMOSWP)
			raw = a + b;
		else
			raw = a + {{16{insn.disp.disp[15]}}, insn.disp.disp};
		if (line)
			adr = ((raw >> LINE_BITS) + 32'd1) << LINE_BITS;
		else
			adr = raw & ~((32'd1 << sz) - 32'd1);
		sel = 4'((32'd1 << (32'd1 << sz)) - 32'd1) << adr[1:0];
		case (sz)
		SZ_BYTE: rep = {4{wdata[7:0]}};
		SZ_HALF: rep = {2{wdata[15:0]}};
		default: rep = wdata;
		endcase
		old = shadow[adr[9:2]];
		lane = old >> (adr[1:0] * 8);
		// only LDB and LDH extend the sign
		if (is_store)
			exp_ld = '0;
		else if (sz == SZ_BYTE)
			exp_ld = (op == LDB) ? {{24{lane[7]}}, lane[7:0]} : {24'd0, lane[7:0]};
		else if (sz == SZ_HALF)
			exp_ld = (op == LDH) ? {{16{lane[15]}}, lane[15:0]} : {16'd0, lane[15:0]};
		else
			exp_ld = old;
		n_exp = (op == AMOSWP) ? 2 : 1;

		@(posedge clk);
		issue_valid <= 1'b1;
		issue_insn <= insn;
		issue_a <= a;
		issue_b <= b;
		issue_data <= wdata;
		next_line <= line;
		// ready was high, this edge takes it
		@(posedge clk);
		issue_valid <= 1'b0;
		n_issued++;

		n_tr = 0;
		held = 1'b0;
		do begin
			@(negedge clk);
			compare("issue_ready", 32'(issue_ready), 32'd0);
			compare("wb_stb", 32'(wb_stb), 32'(wb_cyc));
			// nothing may move while the slave stalls
			if (held) begin
				compare("wb_cyc", 32'(wb_cyc), 32'd1);
				compare("wb_adr", wb_adr, p_adr);
				compare("wb_dat_o", wb_dat_o, p_dat);
				compare("wb_we/wb_sel", 32'({wb_we, wb_sel}), 32'(p_ctl));
			end
			if (wb_cyc && wb_ack) begin
				// swap reads first, then writes
				exp_we = (op == AMOSWP) ? (n_tr == 1) : is_store;
				compare("wb_we", 32'(wb_we), 32'(exp_we));
				compare("wb_adr", wb_adr, adr);
				compare("wb_sel", 32'(wb_sel), 32'(sel));
				if (wb_we)
					compare("wb_dat_o", wb_dat_o, rep);
				n_tr++;
			end
			held = wb_cyc && !wb_ack;
			p_adr = wb_adr;
			p_dat = wb_dat_o;
			p_ctl = {wb_we, wb_sel};
		end while (!done);

		compare("bus cycle count", n_tr, n_exp);
		compare("load_data", load_data, exp_ld);
		if (is_store || op == AMOSWP)
			for (int k = 0; k < 4; k++)
				if (sel[k])
					shadow[adr[9:2]][8*k +: 8] = rep[8*k +: 8];
		// single pulse, ready comes back one cycle later
		@(negedge clk);
		compare("done", 32'(done), 32'd0);
		compare("issue_ready", 32'(issue_ready), 32'd1);
	endtask

	// ==========================================================================
	// random stimulus
	// ==========================================================================

	initial begin : stimulus
		op_t       disp_ops [0:7];
		lsu_insn_u insn;
		addr_t     a;
		addr_t     b;
		addr_t     t;
		addr_t     d;
		data_t     wdata;
		logic      line;
		logic [31:0] r;
		logic [31:0] pick;

		void'($urandom(32'hc26b));
		disp_ops = '{LDB, LDBU, LDH, LDHU, LDW, STB, STH, STW};
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_insn = '0;
		issue_a = '0;
		issue_b = '0;
		issue_data = '0;
		next_line = 1'b0;
		for (int i = 0; i < 256; i++)
			shadow[i] = fill_word(i);

		repeat (RST_CYC - 1) @(posedge clk);
		@(negedge clk);
		compare("wb_cyc", 32'(wb_cyc), 32'd0);
		compare("wb_stb", 32'(wb_stb), 32'd0);
		compare("wb_we", 32'(wb_we), 32'd0);
		compare("done", 32'(done), 32'd0);
		compare("issue_ready", 32'(issue_ready), 32'd1);
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);

		while (n_issued < N_ACC) begin
			r = rand_below(16);
			insn = '0;
			line = 1'b0;
			b = rand_below(32);
			wdata = $urandom;
			// t is the raw target, operands are built around it
			if (r < 32'd8) begin
				pick = rand_below(8);
				d = rand_below(512) - 32'd256;
				line = (rand_below(6) == 32'd0);
				t = line ? rand_below(960) : rand_below(1024);
				insn.disp.opcode = disp_ops[pick[2:0]];
				insn.disp.disp = d[15:0];
				a = t - d;
			end else if (r < 32'd13) begin
				// indexed, displacement mostly negative
				pick = rand_below(3);
				d = rand_below(128) - 32'd96;
				t = rand_below(1024);
				insn.idx.opcode = (rand_below(2) != 32'd0) ? STX : LDX;
				insn.idx.size = size_t'(pick[1:0]);
				pick = rand_below(4);
				insn.idx.sc = pick[1:0];
				insn.idx.disp = d[9:0];
				a = t - (b << insn.idx.sc) - d;
			end else begin
				t = rand_below(1024);
				insn.disp.opcode = AMOSWP;
				a = t - b;
			end
			run_access(insn, a, b, wdata, line);
			// read back what the swap wrote
			if (insn.disp.opcode == AMOSWP) begin
				insn = '0;
				insn.disp.opcode = LDW;
				run_access(insn, t, b, wdata, 1'b0);
			end
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== lsu.f ====
verilog/lsu_pkg.sv
verilog/agen_if.sv
verilog/lsu_agen.sv
verilog/lsu_wb_master.sv
verilog/lsu_top.sv
dv/wb_mem_model.sv
dv/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run of the load/store unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build lsu_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --timescale 1ns/10ps -j 0 \
		--top-module lsu_tb -f lsu.f -o lsu_sim
	-./obj_dir/lsu_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "NO ERRORS" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
